// ==== common/exMemIf.sv ====
`timescale 1ns/1ns

interface exMemIf;
    import mipsPkg::*;

    word_t    aluResult;    // byte address for lw/sw
    word_t    storeData;
    regAddr_t destReg;
    logic     regWrite;
    logic     memRead;
    logic     memWrite;
    logic     isHalt;

    modport producer (output aluResult, storeData, destReg,
                      output regWrite, memRead, memWrite, isHalt);

    modport consumer (input aluResult, storeData, destReg,
                      input regWrite, memRead, memWrite, isHalt);

endinterface

// ==== common/idExIf.sv ====
`timescale 1ns/1ns

interface idExIf;
    import mipsPkg::*;

    regAddr_t   rs;
    regAddr_t   rt;
    word_t      rsVal;
    word_t      rtVal;
    word_t      imm;        // sign extended, rd sits in 15:11
    logic [4:0] shamt;
    aluOp_t     aluOp;
    logic       useImm;
    logic       destIsRt;
    logic       regWrite;
    logic       memRead;
    logic       memWrite;
    logic       isHalt;

    modport producer (output rs, rt, rsVal, rtVal, imm, shamt, aluOp,
                      output useImm, destIsRt, regWrite, memRead, memWrite, isHalt);

    modport consumer (input rs, rt, rsVal, rtVal, imm, shamt, aluOp,
                      input useImm, destIsRt, regWrite, memRead, memWrite, isHalt);

endinterface

// ==== common/mipsPkg.sv ====
package mipsPkg;

    parameter int dataWidth    = 32;
    parameter int regAddrWidth = 5;

    typedef logic [dataWidth-1:0]    word_t;
    typedef logic [regAddrWidth-1:0] regAddr_t;
    typedef logic [5:0]              opcode_t;    // also used for function codes

    // ------------------------------------------------
    // opcodes, bits 31:26
    // ------------------------------------------------
    localparam opcode_t opRType = 6'h00;
    localparam opcode_t opAddi  = 6'h08;
    localparam opcode_t opLw    = 6'h23;
    localparam opcode_t opSw    = 6'h2B;
    localparam opcode_t opHalt  = 6'h3F;

    // R-type function field, bits 5:0
    localparam opcode_t fnAdd = 6'h20;
    localparam opcode_t fnSub = 6'h22;
    localparam opcode_t fnAnd = 6'h24;
    localparam opcode_t fnOr  = 6'h25;
    localparam opcode_t fnSlt = 6'h2A;
    localparam opcode_t fnSll = 6'h00;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt,
        aluSll
    } aluOp_t;

    // operand source picked in execute
    typedef enum logic [1:0] {
        fwdNone,
        fwdExMem,
        fwdMemWb
    } fwdSel_t;

endpackage

// ==== decode/instructionDecode.sv ====
`timescale 1ns/1ns

module instructionDecode (
    input  logic              clk,
    input  logic              i_rst,
    input  logic              i_halt,
    input  mipsPkg::word_t    i_instr,
    input  logic              i_valid,
    input  mipsPkg::word_t    i_wbData,
    input  mipsPkg::regAddr_t i_wbReg,
    input  logic              i_wbEnable,
    output logic              o_stall,
    idExIf.producer           idEx,
    exMemIf.consumer          exMem
);
    import mipsPkg::*;

    word_t    regFile [32];

    opcode_t  opcode;
    opcode_t  funct;
    regAddr_t rs;
    regAddr_t rt;
    regAddr_t rd;
    regAddr_t dest;
    word_t    rsVal;
    word_t    rtVal;

    aluOp_t   aluOp;
    logic     useImm;
    logic     destIsRt;
    logic     regWriteRaw;
    logic     memRead;
    logic     memWrite;
    logic     isHalt;

    assign opcode = i_instr[31:26];
    assign rs     = i_instr[25:21];
    assign rt     = i_instr[20:16];
    assign rd     = i_instr[15:11];
    assign funct  = i_instr[5:0];
    assign dest   = destIsRt ? rt : rd;

    // ------------------------------------------------
    // control decode
    // ------------------------------------------------
    always_comb begin
        aluOp       = aluAdd;
        useImm      = 1'b0;
        destIsRt    = 1'b0;
        regWriteRaw = 1'b0;
        memRead     = 1'b0;
        memWrite    = 1'b0;
        isHalt      = 1'b0;
        case (opcode)
            opRType: begin
                regWriteRaw = 1'b1;
                case (funct)
                    fnAdd:   aluOp = aluAdd;
                    fnSub:   aluOp = aluSub;
                    fnAnd:   aluOp = aluAnd;
                    fnOr:    aluOp = aluOr;
                    fnSlt:   aluOp = aluSlt;
                    fnSll:   aluOp = aluSll;
                    default: regWriteRaw = 1'b0;    // unknown funct is a nop
                endcase
            end
            opAddi: begin
                useImm      = 1'b1;
                destIsRt    = 1'b1;
                regWriteRaw = 1'b1;
            end
            opLw: begin
                useImm      = 1'b1;
                destIsRt    = 1'b1;
                regWriteRaw = 1'b1;
                memRead     = 1'b1;
            end
            opSw: begin
                useImm   = 1'b1;
                memWrite = 1'b1;
            end
            opHalt:  isHalt = 1'b1;
            default: ;
        endcase
    end

    // ------------------------------------------------
    // register file, write-through on read
    // ------------------------------------------------
    always_ff @(posedge clk) begin
        if (i_wbEnable && i_wbReg != '0) begin
            regFile[i_wbReg] <= i_wbData;
        end
    end

    always_comb begin
        if (rs == '0) rsVal = '0;
        else if (i_wbEnable && i_wbReg == rs) rsVal = i_wbData;
        else rsVal = regFile[rs];

        if (rt == '0) rtVal = '0;
        else if (i_wbEnable && i_wbReg == rt) rtVal = i_wbData;
        else rtVal = regFile[rt];
    end

    // load in EX feeding this instruction
    assign o_stall = i_valid && idEx.memRead && idEx.rt != '0
                     && (idEx.rt == rs || idEx.rt == rt);

    // ID/EX flags, zeroed for a bubble
    always_ff @(posedge clk) begin
        if (i_rst) begin
            idEx.regWrite <= 1'b0;
            idEx.memRead  <= 1'b0;
            idEx.memWrite <= 1'b0;
            idEx.isHalt   <= 1'b0;
        end else if (!i_halt) begin
            idEx.regWrite <= i_valid && !o_stall && regWriteRaw && dest != '0;
            idEx.memRead  <= i_valid && !o_stall && memRead;
            idEx.memWrite <= i_valid && !o_stall && memWrite;
            idEx.isHalt   <= i_valid && !o_stall && isHalt;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_halt) begin
            idEx.rs       <= rs;
            idEx.rt       <= rt;
            idEx.rsVal    <= rsVal;
            idEx.rtVal    <= rtVal;
            idEx.imm      <= {{16{i_instr[15]}}, i_instr[15:0]};
            idEx.shamt    <= i_instr[10:6];
            idEx.aluOp    <= aluOp;
            idEx.useImm   <= useImm;
            idEx.destIsRt <= destIsRt;
        end
    end

    // r0 guard holds all the way down the pipe
    noZeroDestEx: assert property (@(posedge clk) disable iff (i_rst)
        exMem.regWrite |-> exMem.destReg != '0)
        else $error("EX/MEM carries a write to register 0");

    noZeroDestWb: assert property (@(posedge clk) disable iff (i_rst)
        i_wbEnable |-> i_wbReg != '0)
        else $error("write-back targets register 0");

endmodule

// ==== dv/mipsPipelineTb.sv ====
`timescale 1ns/1ns

module mipsPipelineTb;
    import mipsPkg::*;

    localparam int progLen    = 15;
    localparam int numWb      = 11;
    localparam int numStores  = 2;
    localparam int endTimeout = 400;    // cycles

    logic     clk;
    logic     i_rst;
    logic     i_halt;
    logic     i_loadWe;
    word_t    i_loadAddr;
    word_t    i_loadData;
    word_t    o_wbData;
    regAddr_t o_wbReg;
    logic     o_wbEnable;
    logic     o_memWe;
    word_t    o_memAddr;
    word_t    o_memWData;
    logic     o_end;

    word_t progWords [progLen];

    // ------------------------------------------------
    // expected retire order, worked out by hand
    // ------------------------------------------------
    regAddr_t expReg [numWb] = '{5'd1, 5'd2, 5'd3, 5'd4, 5'd5, 5'd6,
                                 5'd7, 5'd8, 5'd9, 5'd10, 5'd11};
    word_t    expData [numWb] = '{32'hFFFF_FFFB, 32'h0000_000C, 32'h0000_0007,
                                  32'h0000_000C, 32'h0000_0004, 32'hFFFF_FFFF,
                                  32'h0000_0001, 32'h0000_00C0, 32'h0000_00C0,
                                  32'h0000_00CC, 32'h0000_00CB};
    word_t    expStAddr [numStores] = '{32'h0000_0008, 32'h0000_0010};
    word_t    expStData [numStores] = '{32'h0000_00C0, 32'h0000_00CB};

    int wbIdx;
    int stIdx;
    int valueErrors;
    int eventErrors;
    int timeoutErrors;
    int unsigned lcgState = 34695;

    mipsPipeline dut_i (
        .clk        (clk),
        .i_rst      (i_rst),
        .i_halt     (i_halt),
        .i_loadWe   (i_loadWe),
        .i_loadAddr (i_loadAddr),
        .i_loadData (i_loadData),
        .o_wbData   (o_wbData),
        .o_wbReg    (o_wbReg),
        .o_wbEnable (o_wbEnable),
        .o_memWe    (o_memWe),
        .o_memAddr  (o_memAddr),
        .o_memWData (o_memWData),
        .o_end      (o_end)
    );

    always #20 clk = ~clk;

    function automatic word_t rTypeWord(input regAddr_t rs, input regAddr_t rt,
                                        input regAddr_t rd, input logic [4:0] shamt,
                                        input opcode_t fn);
        return {opRType, rs, rt, rd, shamt, fn};
    endfunction

    function automatic word_t iTypeWord(input opcode_t op, input regAddr_t rs,
                                        input regAddr_t rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic int unsigned nextRandom();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState;
    endfunction

    task automatic matchWriteBack();
        if (o_end || wbIdx >= numWb) begin
            eventErrors++;
            $display("unexpected write-back of r%0d after the last expected one", o_wbReg);
        end else begin
            assert (o_wbReg == expReg[wbIdx]) else begin
                valueErrors++;
                $display("CHECK FAILED o_wbReg: expected %h, got %h", expReg[wbIdx], o_wbReg);
            end
            assert (o_wbData == expData[wbIdx]) else begin
                valueErrors++;
                $display("CHECK FAILED o_wbData: expected %h, got %h",
                         expData[wbIdx], o_wbData);
            end
            wbIdx++;
        end
    endtask

    task automatic inspectStore();
        if (o_end || stIdx >= numStores) begin
            eventErrors++;
            $display("unexpected store to address %h", o_memAddr);
        end else begin
            assert (o_memAddr == expStAddr[stIdx]) else begin
                valueErrors++;
                $display("CHECK FAILED o_memAddr: expected %h, got %h",
                         expStAddr[stIdx], o_memAddr);
            end
            assert (o_memWData == expStData[stIdx]) else begin
                valueErrors++;
                $display("CHECK FAILED o_memWData: expected %h, got %h",
                         expStData[stIdx], o_memWData);
            end
            stIdx++;
        end
    endtask

    // events count on the edge that applies them
    always @(posedge clk) begin
        if (!i_rst) begin
            if (o_wbEnable) matchWriteBack();
            if (o_memWe) inspectStore();
        end
    end

    initial begin
        int cycles;
        int pulseLeft;
        int unsigned r;

        clk        = 1'b0;
        i_rst      = 1'b1;
        i_halt     = 1'b1;
        i_loadWe   = 1'b0;
        i_loadAddr = '0;
        i_loadData = '0;
        wbIdx      = 0;
        stIdx      = 0;
        valueErrors   = 0;
        eventErrors   = 0;
        timeoutErrors = 0;
        pulseLeft     = 0;

        progWords = '{
            iTypeWord(opAddi, 5'd0, 5'd1, 16'hFFFB),     // addi r1, r0, -5
            iTypeWord(opAddi, 5'd0, 5'd2, 16'd12),       // addi r2, r0, 12
            rTypeWord(5'd1, 5'd2, 5'd3, 5'd0, fnAdd),    // add r3, r1, r2
            rTypeWord(5'd3, 5'd1, 5'd4, 5'd0, fnSub),    // sub r4, r3, r1
            rTypeWord(5'd4, 5'd3, 5'd5, 5'd0, fnAnd),    // and r5, r4, r3
            rTypeWord(5'd5, 5'd1, 5'd6, 5'd0, fnOr),     // or  r6, r5, r1
            rTypeWord(5'd1, 5'd2, 5'd7, 5'd0, fnSlt),    // slt r7, r1, r2
            rTypeWord(5'd0, 5'd2, 5'd8, 5'd4, fnSll),    // sll r8, r2, 4
            iTypeWord(opSw, 5'd0, 5'd8, 16'd8),          // sw r8, 8(r0)
            iTypeWord(opLw, 5'd0, 5'd9, 16'd8),          // lw r9, 8(r0)
            rTypeWord(5'd9, 5'd2, 5'd10, 5'd0, fnAdd),   // load-use pair
            iTypeWord(opAddi, 5'd3, 5'd0, 16'd100),      // r0 target, no event
            rTypeWord(5'd10, 5'd6, 5'd11, 5'd0, fnAdd),  // add r11, r10, r6
            iTypeWord(opSw, 5'd2, 5'd11, 16'd4),         // sw r11, 4(r2)
            {opHalt, 26'd0}
        };

        repeat (8) @(negedge clk);
        i_rst = 1'b0;

        // program load while frozen
        for (int i = 0; i < progLen; i++) begin
            @(negedge clk);
            i_loadWe   = 1'b1;
            i_loadAddr = i;
            i_loadData = progWords[i];
        end
        @(negedge clk);
        i_loadWe = 1'b0;

        // ------------------------------------------------
        // run with random freeze pulses until o_end
        // ------------------------------------------------
        cycles = 0;
        while (!o_end && cycles < endTimeout) begin
            @(negedge clk);
            if (pulseLeft != 0) begin
                i_halt = 1'b1;
                pulseLeft--;
            end else begin
                i_halt = 1'b0;
                r = nextRandom();
                if ((r >> 16) % 6 == 0) pulseLeft = 1 + (r >> 20) % 3;    // 1..3 cycles
            end
            cycles++;
        end
        if (!o_end) begin
            timeoutErrors++;
            $display("timeout: o_end did not rise within %0d cycles", endTimeout);
        end

        i_halt = 1'b0;
        repeat (10) @(negedge clk);    // nothing may retire now

        if (wbIdx != numWb || stIdx != numStores) begin
            eventErrors++;
            $display("missing events: %0d of %0d write-backs and %0d of %0d stores seen",
                     wbIdx, numWb, stIdx, numStores);
        end

        $display("errors: value=%0d event=%0d timeout=%0d",
                 valueErrors, eventErrors, timeoutErrors);
        if (valueErrors + eventErrors + timeoutErrors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== execute/instructionExecute.sv ====
`timescale 1ns/1ns

module instructionExecute (
    input  logic              clk,
    input  logic              i_rst,
    input  logic              i_halt,
    input  mipsPkg::word_t    i_wbData,
    input  mipsPkg::regAddr_t i_wbReg,
    input  logic              i_wbEnable,
    idExIf.consumer           idEx,
    exMemIf.producer          exMem
);
    import mipsPkg::*;

    fwdSel_t  fwdA;
    fwdSel_t  fwdB;
    word_t    opA;
    word_t    opB;          // forwarded rt, also the store data
    word_t    aluIn2;
    word_t    aluResult;
    regAddr_t dest;

    // youngest writer wins
    function automatic fwdSel_t pickFwd(input regAddr_t src);
        if (exMem.regWrite && exMem.destReg == src) return fwdExMem;
        if (i_wbEnable && i_wbReg == src) return fwdMemWb;
        return fwdNone;
    endfunction

    function automatic word_t fwdMux(input fwdSel_t sel, input word_t regVal);
        case (sel)
            fwdExMem: return exMem.aluResult;
            fwdMemWb: return i_wbData;
            default:  return regVal;
        endcase
    endfunction

    assign fwdA   = pickFwd(idEx.rs);
    assign fwdB   = pickFwd(idEx.rt);
    assign opA    = fwdMux(fwdA, idEx.rsVal);
    assign opB    = fwdMux(fwdB, idEx.rtVal);
    assign aluIn2 = idEx.useImm ? idEx.imm : opB;
    assign dest   = idEx.destIsRt ? idEx.rt : idEx.imm[15:11];    // rd field

    // ------------------------------------------------
    // ALU
    // ------------------------------------------------
    always_comb begin
        case (idEx.aluOp)
            aluSub:  aluResult = opA - aluIn2;
            aluAnd:  aluResult = opA & aluIn2;
            aluOr:   aluResult = opA | aluIn2;
            aluSlt:  aluResult = {31'b0, $signed(opA) < $signed(aluIn2)};
            aluSll:  aluResult = opB << idEx.shamt;    // sll shifts rt
            default: aluResult = opA + aluIn2;
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            exMem.regWrite <= 1'b0;
            exMem.memRead  <= 1'b0;
            exMem.memWrite <= 1'b0;
            exMem.isHalt   <= 1'b0;
        end else if (!i_halt) begin
            exMem.regWrite <= idEx.regWrite;
            exMem.memRead  <= idEx.memRead;
            exMem.memWrite <= idEx.memWrite;
            exMem.isHalt   <= idEx.isHalt;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_halt) begin
            exMem.aluResult <= aluResult;
            exMem.storeData <= opB;
            exMem.destReg   <= dest;
        end
    end

    // decode must never mark one instruction as load and store
    loadXorStore: assert property (@(posedge clk) disable iff (i_rst)
        !(exMem.memRead && exMem.memWrite))
        else $error("EX/MEM has memRead and memWrite both set");

endmodule

// ==== fetch/instructionFetch.sv ====
`timescale 1ns/1ns

module instructionFetch #(
    parameter int imemDepthLog2 = 6
) (
    input  logic           clk,
    input  logic           i_rst,
    input  logic           i_halt,
    input  logic           i_stall,
    input  logic           i_loadWe,
    input  mipsPkg::word_t i_loadAddr,     // word index
    input  mipsPkg::word_t i_loadData,
    output mipsPkg::word_t o_instr,
    output logic           o_valid
);
    import mipsPkg::*;

    localparam int imemDepth = 2 ** imemDepthLog2;

    word_t imem [imemDepth];
    word_t pc;              // word index, not bytes
    word_t fetchWord;
    logic  haltSeen;        // halt already sent to decode
    logic  advance;

    assign fetchWord = imem[pc[imemDepthLog2-1:0]];
    assign advance   = !i_halt && !i_stall;

    // loader writes go through even while frozen
    always_ff @(posedge clk) begin
        if (i_loadWe) begin
            imem[i_loadAddr[imemDepthLog2-1:0]] <= i_loadData;
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            pc       <= '0;
            o_valid  <= 1'b0;
            haltSeen <= 1'b0;
        end else if (advance) begin
            if (haltSeen) begin
                o_valid <= 1'b0;    // only bubbles behind the halt
            end else begin
                pc       <= pc + 1'b1;
                o_valid  <= 1'b1;
                haltSeen <= (fetchWord[31:26] == opHalt);
            end
        end
    end

    // IF/ID payload
    always_ff @(posedge clk) begin
        if (advance && !haltSeen) begin
            o_instr <= fetchWord;
        end
    end

    pcInRange: assert property (@(posedge clk) disable iff (i_rst)
        advance && !haltSeen |-> pc < imemDepth)
        else $error("fetch PC %0d beyond instruction memory", pc);

endmodule

// ==== filelist.f ====
common/mipsPkg.sv
common/idExIf.sv
common/exMemIf.sv
fetch/instructionFetch.sv
decode/instructionDecode.sv
execute/instructionExecute.sv
memory/memoryAccess.sv
source/mipsPipeline.sv
dv/mipsPipelineTb.sv

// ==== memory/memoryAccess.sv ====
`timescale 1ns/1ns

module memoryAccess #(
    parameter int dmemDepthLog2 = 6
) (
    input  logic              clk,
    input  logic              i_rst,
    input  logic              i_halt,
    exMemIf.consumer          exMem,
    output mipsPkg::word_t    o_wbData,
    output mipsPkg::regAddr_t o_wbReg,
    output logic              o_wbEnable,
    output logic              o_memWe,
    output mipsPkg::word_t    o_memAddr,
    output mipsPkg::word_t    o_memWData,
    output logic              o_end
);
    import mipsPkg::*;

    localparam int dmemDepth = 2 ** dmemDepthLog2;

    word_t dmem [dmemDepth];
    word_t readData;
    logic  wbValid;
    logic  wbHalt;     // halt sitting in MEM/WB

    // byte address in, word index into the array
    assign readData   = dmem[exMem.aluResult[dmemDepthLog2+1:2]];

    assign o_memWe    = exMem.memWrite && !i_halt;    // one strobe per store
    assign o_memAddr  = exMem.aluResult;
    assign o_memWData = exMem.storeData;
    assign o_wbEnable = wbValid && !i_halt;

    always_ff @(posedge clk) begin
        if (o_memWe) begin
            dmem[exMem.aluResult[dmemDepthLog2+1:2]] <= exMem.storeData;
        end
    end

    // ------------------------------------------------
    // MEM/WB register and end flag
    // ------------------------------------------------
    always_ff @(posedge clk) begin
        if (i_rst) begin
            wbValid <= 1'b0;
            wbHalt  <= 1'b0;
            o_end   <= 1'b0;
        end else begin
            if (!i_halt) begin
                wbValid <= exMem.regWrite;
                wbHalt  <= exMem.isHalt;
            end
            if (wbHalt) o_end <= 1'b1;    // sticky
        end
    end

    always_ff @(posedge clk) begin
        if (!i_halt) begin
            o_wbData <= exMem.memRead ? readData : exMem.aluResult;
            o_wbReg  <= exMem.destReg;
        end
    end

endmodule

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module mipsPipelineTb \
    -f filelist.f -o simv &&
./obj_dir/simv | tee /dev/stderr | grep "Simulation PASSED" > /dev/null ||
{ echo "run.sh: simulation did not pass" >&2; exit 1; }

// ==== source/mipsPipeline.sv ====
`timescale 1ns/1ns

module mipsPipeline #(
    parameter int imemDepthLog2 = 6,
    parameter int dmemDepthLog2 = 6
) (
    input  logic              clk,
    input  logic              i_rst,
    input  logic              i_halt,
    input  logic              i_loadWe,
    input  mipsPkg::word_t    i_loadAddr,
    input  mipsPkg::word_t    i_loadData,
    output mipsPkg::word_t    o_wbData,
    output mipsPkg::regAddr_t o_wbReg,
    output logic              o_wbEnable,
    output logic              o_memWe,
    output mipsPkg::word_t    o_memAddr,
    output mipsPkg::word_t    o_memWData,
    output logic              o_end
);
    import mipsPkg::*;

    word_t instrIfId;
    logic  validIfId;
    logic  stall;

    idExIf  idEx ();
    exMemIf exMem ();

    instructionFetch #(
        .imemDepthLog2 (imemDepthLog2)
    ) fetch_i (
        .clk        (clk),
        .i_rst      (i_rst),
        .i_halt     (i_halt),
        .i_stall    (stall),
        .i_loadWe   (i_loadWe),
        .i_loadAddr (i_loadAddr),
        .i_loadData (i_loadData),
        .o_instr    (instrIfId),
        .o_valid    (validIfId)
    );

    instructionDecode decode_i (
        .clk        (clk),
        .i_rst      (i_rst),
        .i_halt     (i_halt),
        .i_instr    (instrIfId),
        .i_valid    (validIfId),
        .i_wbData   (o_wbData),       // write-back feeds the register file
        .i_wbReg    (o_wbReg),
        .i_wbEnable (o_wbEnable),
        .o_stall    (stall),
        .idEx       (idEx.producer),
        .exMem      (exMem.consumer)
    );

    instructionExecute execute_i (
        .clk        (clk),
        .i_rst      (i_rst),
        .i_halt     (i_halt),
        .i_wbData   (o_wbData),       // MEM/WB forwarding source
        .i_wbReg    (o_wbReg),
        .i_wbEnable (o_wbEnable),
        .idEx       (idEx.consumer),
        .exMem      (exMem.producer)
    );

    memoryAccess #(
        .dmemDepthLog2 (dmemDepthLog2)
    ) memory_i (
        .clk        (clk),
        .i_rst      (i_rst),
        .i_halt     (i_halt),
        .exMem      (exMem.consumer),
        .o_wbData   (o_wbData),
        .o_wbReg    (o_wbReg),
        .o_wbEnable (o_wbEnable),
        .o_memWe    (o_memWe),
        .o_memAddr  (o_memAddr),
        .o_memWData (o_memWData),
        .o_end      (o_end)
    );

endmodule
